//--- sim.f
+incdir+test
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/instr_decoder.sv
hw/run_fsm.sv
hw/phase_counter.sv
hw/ctrl_table.sv
hw/control_unit.sv
test/control_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module control_unit_tb -o control_unit_tb_sim

# The log decides the result, so a failing run must not end the script here
./obj_dir/control_unit_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
grep -q "Test passed" sim.log

//--- test/ctrl_model.svh
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

run_state_t m_rs;    // Expected run state
phase_t     m_phase;
cmd_t       m_cmd;
ctrl_word_t m_ctrl;  // Expected registered control word
int         m_done;  // Instructions that left write back

function automatic cmd_t decode_cmd(instr_t i, flags_t f);
	cmd_t c;
	logic lt;
	c = CMD_NOP;
	lt = f.s ^ f.v; // Signed less than
	if (i.op == OP_LD) begin
		c = CMD_LD;
	end else if (i.op == OP_ST) begin
		c = CMD_ST;
	end else if (i.op == OP_ALU) begin
		if (i.alu_op != 4'd7 && i.alu_op != 4'd14) c = cmd_t'({1'b0, i.alu_op});
	end else if (i.ra == 3'd0) begin
		c = CMD_LI;
	end else if (i.ra == 3'd4) begin
		c = CMD_B;
	end else if (i.ra == 3'd7) begin
		case (i.rb)
			3'd0: c = f.z ? CMD_BE : CMD_NOP;
			3'd1: c = lt ? CMD_BLT : CMD_NOP;
			3'd2: c = (f.z || lt) ? CMD_BLE : CMD_NOP;
			3'd3: c = f.z ? CMD_NOP : CMD_BNE;
			default: c = CMD_NOP;
		endcase
	end
	return c;
endfunction

function automatic alu_sel_t alu_select(instr_t i);
	if (i.op == OP_ALU) return {i.op, i.alu_op};
	return {i.op, i.ra, i.rb[2]};
endfunction

function automatic ctrl_word_t table_row(phase_t ph, cmd_t c);
	ctrl_word_t w;
	logic alu;
	logic sh;
	logic br;
	logic ldst;
	w = CTRL_IDLE;
	alu = c inside {CMD_ADD, CMD_SUB, CMD_AND, CMD_OR, CMD_XOR, CMD_CMP, CMD_MOV};
	sh = c inside {CMD_SLL, CMD_SLR, CMD_SRL, CMD_SRA};
	br = c inside {CMD_B, CMD_BE, CMD_BLT, CMD_BLE, CMD_BNE}; // Taken only, NOP otherwise
	ldst = (c == CMD_LD) || (c == CMD_ST);
	case (ph)
		PH_FETCH: w = '{reg_e: 1'b1, pc_e: 1'b1, mem_e: 1'b1, default: 1'b0};
		PH_DECODE: begin
			if (alu || c == CMD_HLT) w = '{ir_e: 1'b1, reg_e: 1'b1, default: 1'b0};
			else if (sh || ldst) w = '{ir_e: 1'b1, reg_e: 1'b1, m2_s: 1'b1, default: 1'b0};
			else if (c == CMD_LI)
				w = '{ir_e: 1'b1, reg_e: 1'b1, m2_s: 1'b1, m8_s: 1'b1, default: 1'b0};
			else if (br)
				w = '{ir_e: 1'b1, reg_e: 1'b1, m2_s: 1'b1, m3_s: 1'b1, default: 1'b0};
			else if (c == CMD_OUT) w = '{ar_e: 1'b1, reg_e: 1'b1, default: 1'b0};
		end
		PH_EXEC: begin
			if (c == CMD_MOV) w = '{aluc_e: 1'b1, ar_e: 1'b1, reg_e: 1'b1, default: 1'b0};
			else if (alu)
				w = '{aluc_e: 1'b1, ar_e: 1'b1, br_e: 1'b1, reg_e: 1'b1, default: 1'b0};
			else if (sh || ldst)
				w = '{aluc_e: 1'b1, br_e: 1'b1, reg_e: 1'b1, m2_s: 1'b1, default: 1'b0};
			else if (c == CMD_LI) w = '{m8_s: 1'b1, default: 1'b0};
			else if (br)
				w = '{aluc_e: 1'b1, reg_e: 1'b1, m2_s: 1'b1, m3_s: 1'b1, default: 1'b0};
		end
		PH_MEM: begin
			if (c == CMD_IN) w = '{reg_e: 1'b1, default: 1'b0};
			else if (c == CMD_OUT) w = '{ar_e: 1'b1, reg_e: 1'b1, default: 1'b0};
			else if (c == CMD_LD)
				w = '{dr_e: 1'b1, mdr_e: 1'b1, ir_e: 1'b1, reg_e: 1'b1, mem_e: 1'b1,
					m6_s: 1'b1, m7_s: 1'b1, default: 1'b0};
			else if (c == CMD_ST)
				w = '{ar_e: 1'b1, dr_e: 1'b1, ir_e: 1'b1, reg_e: 1'b1, mem_e: 1'b1,
					mem_w: 1'b1, m6_s: 1'b1, default: 1'b0};
		end
		PH_WB: begin
			if ((alu && c != CMD_CMP) || sh)
				w = '{dr_e: 1'b1, reg_e: 1'b1, genr_w: 1'b1, m5_s: 1'b1, default: 1'b0};
			else if (c == CMD_IN) w = '{genr_w: 1'b1, m4_s: 1'b1, m5_s: 1'b1, default: 1'b0};
			else if (c == CMD_LD)
				w = '{dr_e: 1'b1, reg_e: 1'b1, genr_w: 1'b1, mem_e: 1'b1, m4_s: 1'b1,
					m6_s: 1'b1, m7_s: 1'b1, default: 1'b0};
			else if (c == CMD_ST)
				w = '{ar_e: 1'b1, dr_e: 1'b1, reg_e: 1'b1, mem_w: 1'b1, m6_s: 1'b1,
					default: 1'b0};
			else if (c == CMD_LI) w = '{genr_w: 1'b1, m5_s: 1'b1, m8_s: 1'b1, default: 1'b0};
			else if (br) w = '{dr_e: 1'b1, default: 1'b0};
		end
		default: w = CTRL_IDLE;
	endcase
	return w;
endfunction

task automatic model_reset();
	m_rs = RS_IDLE;
	m_phase = PH_IDLE;
	m_cmd = CMD_NOP;
	m_ctrl = CTRL_IDLE;
	m_done = 0;
endtask

// One rising edge, with the inputs that the edge samples
task automatic model_step(input logic ex, input instr_t i, input flags_t f);
	logic run;
	run = (m_rs != RS_IDLE);
	m_ctrl = table_row(m_phase, m_cmd);
	if (m_rs != RS_IDLE) begin
		if (m_phase == PH_WB) begin
			if (m_rs == RS_STOPPING || ex || m_cmd == CMD_HLT) m_rs = RS_IDLE;
		end else if (ex) begin
			m_rs = RS_STOPPING; // Finish the current instruction first
		end
	end else if (ex) begin
		m_rs = RS_RUN;
	end
	if (m_phase == PH_FETCH) m_cmd = decode_cmd(i, f);
	if (m_phase == PH_WB) begin
		m_phase = PH_IDLE;
		m_done++;
	end else if (m_phase == PH_IDLE) begin
		if (run) m_phase = PH_FETCH;
	end else begin
		m_phase = phase_t'(m_phase + 3'd1);
	end
endtask

`endif

//--- test/control_unit_tb.sv
`timescale 1ns/1ps

module control_unit_tb
	import isa_pkg::*;
	import ctrl_pkg::*;
;

	localparam int N_INSTR     = 200;
	localparam int RESTART_GAP = 3; // Idle cycles before exec restarts a stopped run
	// Worst case is a stop and restart after every instruction
	localparam int LIMIT = N_INSTR * (6 + RESTART_GAP + 2) + 100;

	logic       clk;
	logic       rst;
	logic       exec;
	instr_t     instruction;
	flags_t     flags;
	ctrl_word_t ctrl;
	alu_sel_t   alu_instruction;
	logic       running;

	integer seed;
	int     cycles;
	int     idle_cnt;
	int     n_loaded;
	string  test_name;

	`include "ctrl_model.svh"

	control_unit control_unit_inst (
		.clk             (clk),
		.rst             (rst),
		.exec            (exec),
		.instruction     (instruction),
		.flags           (flags),
		.ctrl            (ctrl),
		.alu_instruction (alu_instruction),
		.running         (running)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_on_error();
		$display("Test failed");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	task automatic check_ctrl(input ctrl_word_t exp, input ctrl_word_t act);
		if (act !== exp) begin
			$display("ERROR %s ctrl expected %h actual %h", test_name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_alu(input alu_sel_t exp, input alu_sel_t act);
		if (act !== exp) begin
			$display("ERROR %s alu_instruction expected %h actual %h", test_name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_running(input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %s running expected %b actual %b", test_name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_outputs();
		check_ctrl(m_ctrl, ctrl);
		check_running(m_rs != RS_IDLE, running);
		check_alu(alu_select(instruction), alu_instruction);
	endtask

	// Directed branches and a halt first, then random words
	task automatic load_instruction();
		logic [31:0] rnd;
		logic        take;
		instr_t      i;
		flags_t      f;
		rnd = $random(seed);
		i = instr_t'(rnd[15:0]);
		f = flags_t'(rnd[18:16]);
		take = !n_loaded[0];
		if (n_loaded < 8) begin
			test_name = "branch";
			i.op = OP_IMM;
			i.ra = 3'd7;
			i.rb = {1'b0, n_loaded[2:1]};
			case (n_loaded[2:1])
				2'd0: f = take ? 3'b010 : 3'b000;
				2'd1: f = take ? 3'b100 : 3'b101; // s equal to v is not less
				2'd2: f = take ? 3'b001 : 3'b000;
				default: f = take ? 3'b000 : 3'b010;
			endcase
		end else if (n_loaded == 8) begin
			test_name = "halt";
			i.op = OP_ALU;
			i.alu_op = 4'd15;
		end else begin
			test_name = "random";
			if (i.op == OP_IMM && rnd[22]) begin
				case (rnd[31:25] % 7'd3)
					7'd0: i.ra = 3'd0;
					7'd1: i.ra = 3'd4;
					default: i.ra = 3'd7;
				endcase
			end
		end
		instruction = i;
		flags = f;
		n_loaded++;
	endtask

	task automatic choose_exec(output logic ex);
		logic [31:0] rnd;
		rnd = $random(seed);
		ex = 1'b0;
		if (m_rs == RS_IDLE) begin
			idle_cnt++;
			if (idle_cnt >= RESTART_GAP) begin
				ex = 1'b1; // Restart after a stop
				idle_cnt = 0;
			end
		end else begin
			ex = (rnd[5:0] == 6'd0); // Occasional stop request
		end
	endtask

	// Drive at the falling edge, check at the next one
	task automatic advance(input logic ex);
		exec = ex;
		model_step(ex, instruction, flags);
		@(negedge clk);
		cycles++;
		if (cycles > LIMIT) begin
			$display("Timeout, the run did not finish within %0d cycles", LIMIT);
			$display("Test failed");
			$fatal(1, "Timeout");
		end
		check_outputs();
	endtask

	initial begin
		logic ex;
		seed = 32'h21c7bbd6;
		rst = 1'b1;
		exec = 1'b0;
		instruction = '0;
		flags = '0;
		cycles = 0;
		idle_cnt = 0;
		n_loaded = 0;
		test_name = "reset";
		model_reset();
		repeat (4) @(negedge clk);
		rst = 1'b0;
		check_outputs();
		load_instruction();
		while (m_done < N_INSTR) begin
			choose_exec(ex);
			advance(ex);
			if (m_phase == PH_DECODE) load_instruction(); // Fetch row is on ctrl now
		end
		repeat (2) advance(1'b0);
		$display("Test passed");
		$finish;
	end

endmodule

//--- hw/control_unit.sv
`timescale 1ns/1ps

module control_unit
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       exec,
	input  instr_t     instruction,
	input  flags_t     flags,
	output ctrl_word_t ctrl,
	output alu_sel_t   alu_instruction,
	output logic       running
);

	logic   run;
	logic   instr_end;
	phase_t phase;
	cmd_t   cmd;

	assign running = run;

	instr_decoder instr_decoder_inst (
		.clk             (clk),
		.rst             (rst),
		.instruction     (instruction),
		.flags           (flags),
		.phase           (phase),
		.cmd             (cmd),
		.alu_instruction (alu_instruction)
	);

	run_fsm run_fsm_inst (
		.clk       (clk),
		.rst       (rst),
		.exec      (exec),
		.instr_end (instr_end),
		.cmd       (cmd),
		.run       (run)
	);

	phase_counter phase_counter_inst (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.phase     (phase),
		.instr_end (instr_end)
	);

	ctrl_table ctrl_table_inst (
		.clk   (clk),
		.rst   (rst),
		.phase (phase),
		.cmd   (cmd),
		.ctrl  (ctrl)
	);

endmodule

//--- hw/ctrl_table.sv
`timescale 1ns/1ps

module ctrl_table
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  phase_t     phase,
	input  cmd_t       cmd,
	output ctrl_word_t ctrl
);

	logic       is_alu;   // ADD to XOR, CMP, MOV
	logic       is_shift;
	logic       is_br;    // Taken branches only
	ctrl_word_t row;

	assign is_alu   = (cmd <= CMD_MOV);
	assign is_shift = (cmd == CMD_SLL) || (cmd == CMD_SLR) ||
		(cmd == CMD_SRL) || (cmd == CMD_SRA);
	assign is_br    = (cmd == CMD_B) || (cmd == CMD_BE) || (cmd == CMD_BLT) ||
		(cmd == CMD_BLE) || (cmd == CMD_BNE);

	always_comb begin
		row = CTRL_IDLE;
		case (phase)
			PH_FETCH: begin
				row.reg_e = 1'b1;
				row.pc_e  = 1'b1; // PC increment
				row.mem_e = 1'b1; // Instruction read
			end
			PH_DECODE: begin
				if (is_alu || cmd == CMD_HLT) begin
					row.ir_e  = 1'b1;
					row.reg_e = 1'b1;
				end else if (is_shift || cmd == CMD_LD || cmd == CMD_ST) begin
					row.ir_e  = 1'b1;
					row.reg_e = 1'b1;
					row.m2_s  = 1'b1; // Displacement from IR
				end else if (cmd == CMD_LI) begin
					row.ir_e  = 1'b1;
					row.reg_e = 1'b1;
					row.m2_s  = 1'b1;
					row.m8_s  = 1'b1;
				end else if (is_br) begin
					row.ir_e  = 1'b1;
					row.reg_e = 1'b1;
					row.m2_s  = 1'b1;
					row.m3_s  = 1'b1; // PC+1 as ALU operand
				end else if (cmd == CMD_OUT) begin
					row.ar_e  = 1'b1; // Ra into AR
					row.reg_e = 1'b1;
				end
			end
			PH_EXEC: begin
				if (is_alu) begin
					row.aluc_e = 1'b1;
					row.ar_e   = 1'b1;
					row.br_e   = (cmd != CMD_MOV); // MOV needs only Ra
					row.reg_e  = 1'b1;
				end else if (is_shift || cmd == CMD_LD || cmd == CMD_ST) begin
					row.aluc_e = 1'b1;
					row.br_e   = 1'b1;
					row.reg_e  = 1'b1;
					row.m2_s   = 1'b1;
				end else if (cmd == CMD_LI) begin
					row.m8_s = 1'b1;
				end else if (is_br) begin
					row.aluc_e = 1'b1; // Branch target
					row.reg_e  = 1'b1;
					row.m2_s   = 1'b1;
					row.m3_s   = 1'b1;
				end
			end
			PH_MEM: begin
				case (cmd)
					CMD_IN: row.reg_e = 1'b1;
					CMD_OUT: begin
						row.ar_e  = 1'b1; // Ra straight to the output port
						row.reg_e = 1'b1;
					end
					CMD_LD: begin
						row.dr_e  = 1'b1;
						row.mdr_e = 1'b1;
						row.ir_e  = 1'b1;
						row.reg_e = 1'b1;
						row.mem_e = 1'b1;
						row.m6_s  = 1'b1; // DR as address
						row.m7_s  = 1'b1;
					end
					CMD_ST: begin
						row.ar_e  = 1'b1; // Store data
						row.dr_e  = 1'b1;
						row.ir_e  = 1'b1;
						row.reg_e = 1'b1;
						row.mem_e = 1'b1;
						row.mem_w = 1'b1;
						row.m6_s  = 1'b1;
					end
					default: row = CTRL_IDLE;
				endcase
			end
			PH_WB: begin
				if ((is_alu && cmd != CMD_CMP) || is_shift) begin
					row.dr_e   = 1'b1;
					row.reg_e  = 1'b1;
					row.genr_w = 1'b1;
					row.m5_s   = 1'b1; // Write address is Rd
				end else if (cmd == CMD_IN) begin
					row.genr_w = 1'b1;
					row.m4_s   = 1'b1; // External input as write data
					row.m5_s   = 1'b1;
				end else if (cmd == CMD_LD) begin
					row.dr_e   = 1'b1;
					row.reg_e  = 1'b1;
					row.genr_w = 1'b1;
					row.mem_e  = 1'b1;
					row.m4_s   = 1'b1;
					row.m6_s   = 1'b1;
					row.m7_s   = 1'b1;
				end else if (cmd == CMD_ST) begin
					row.ar_e  = 1'b1;
					row.dr_e  = 1'b1;
					row.reg_e = 1'b1;
					row.mem_w = 1'b1;
					row.m6_s  = 1'b1;
				end else if (cmd == CMD_LI) begin
					row.genr_w = 1'b1;
					row.m5_s   = 1'b1; // Rb is the target
					row.m8_s   = 1'b1;
				end else if (is_br) begin
					row.dr_e = 1'b1; // New PC from DR
				end
			end
			default: row = CTRL_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl <= CTRL_IDLE;
		end else begin
			ctrl <= row;
		end
	end

endmodule

//--- hw/phase_counter.sv
`timescale 1ns/1ps

module phase_counter
	import ctrl_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   run,
	output phase_t phase,
	output logic   instr_end
);

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= PH_IDLE;
		end else begin
			case (phase)
				PH_IDLE:   if (run) phase <= PH_FETCH; // Wait for start
				PH_FETCH:  phase <= PH_DECODE;
				PH_DECODE: phase <= PH_EXEC;
				PH_EXEC:   phase <= PH_MEM;
				PH_MEM:    phase <= PH_WB;
				PH_WB:     phase <= PH_IDLE; // Always one idle cycle between instructions
				default:   phase <= PH_IDLE;
			endcase
		end
	end

	assign instr_end = (phase == PH_WB);

endmodule

//--- hw/run_fsm.sv
`timescale 1ns/1ps

module run_fsm
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic exec,      // Level, start or stop request
	input  logic instr_end, // Write back phase
	input  cmd_t cmd,
	output logic run
);

	run_state_t state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RS_IDLE;
		end else begin
			case (state)
				RS_IDLE: begin
					if (exec) state <= RS_RUN;
				end
				RS_RUN: begin
					// Exec in the last phase also stops after this instruction
					if (instr_end) begin
						state <= (exec || cmd == CMD_HLT) ? RS_IDLE : RS_RUN;
					end else if (exec) begin
						state <= RS_STOPPING;
					end
				end
				RS_STOPPING: begin
					if (instr_end) state <= RS_IDLE;
				end
				default: state <= RS_IDLE;
			endcase
		end
	end

	assign run = (state != RS_IDLE);

endmodule

//--- hw/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  instr_t   instruction,
	input  flags_t   flags,
	input  phase_t   phase,
	output cmd_t     cmd,
	output alu_sel_t alu_instruction
);

	logic sv_lt;      // Signed less than
	cmd_t branch_cmd;
	cmd_t next_cmd;

	assign sv_lt = flags.s ^ flags.v;

	// Conditional branches, a false condition decodes to NOP
	always_comb begin
		branch_cmd = CMD_NOP;
		case (instruction.rb)
			3'd0: if (flags.z) branch_cmd = CMD_BE;
			3'd1: if (sv_lt) branch_cmd = CMD_BLT;
			3'd2: if (flags.z || sv_lt) branch_cmd = CMD_BLE;
			3'd3: if (!flags.z) branch_cmd = CMD_BNE;
			default: branch_cmd = CMD_NOP;
		endcase
	end

	always_comb begin
		next_cmd = CMD_NOP;
		case (instruction.op)
			OP_LD: next_cmd = CMD_LD;
			OP_ST: next_cmd = CMD_ST;
			OP_IMM: begin
				case (instruction.ra)
					3'd0: next_cmd = CMD_LI;
					3'd4: next_cmd = CMD_B;
					3'd7: next_cmd = branch_cmd;
					default: next_cmd = CMD_NOP;
				endcase
			end
			OP_ALU: begin
				// Codes 7 and 14 are unassigned
				if (instruction.alu_op == 4'd7 || instruction.alu_op == 4'd14) begin
					next_cmd = CMD_NOP;
				end else begin
					next_cmd = cmd_t'({1'b0, instruction.alu_op});
				end
			end
			default: next_cmd = CMD_NOP;
		endcase
	end

	// Command is taken at the end of fetch and held until the next one
	always_ff @(posedge clk) begin
		if (rst) begin
			cmd <= CMD_NOP;
		end else if (phase == PH_FETCH) begin
			cmd <= next_cmd;
		end
	end

	assign alu_instruction = (instruction.op == OP_ALU) ?
		{instruction.op, instruction.alu_op} :
		{instruction.op, instruction.ra, instruction.rb[2]};

endmodule

//--- hw/ctrl_pkg.sv
package ctrl_pkg;

	typedef enum logic [2:0] {
		PH_IDLE   = 3'd0,
		PH_FETCH  = 3'd1,
		PH_DECODE = 3'd2, // Decode and register read
		PH_EXEC   = 3'd3,
		PH_MEM    = 3'd4, // Memory access, IN and OUT
		PH_WB     = 3'd5  // Register write back
	} phase_t;

	typedef enum logic [1:0] {
		RS_IDLE     = 2'd0,
		RS_RUN      = 2'd1,
		RS_STOPPING = 2'd2 // Stop after this instruction
	} run_state_t;

	// Datapath enables and mux selects
	typedef struct packed {
		logic aluc_e;
		logic ar_e;
		logic br_e;
		logic dr_e;
		logic mdr_e;
		logic ir_e;
		logic reg_e;  // All non-general registers
		logic genr_w; // General register write
		logic pc_e;
		logic mem_e;
		logic mem_w;
		logic m2_s;
		logic m3_s;
		logic m4_s;
		logic m5_s;
		logic m6_s;
		logic m7_s;
		logic m8_s;
	} ctrl_word_t;

	localparam ctrl_word_t CTRL_IDLE = '0;

endpackage

//--- hw/isa_pkg.sv
package isa_pkg;

	localparam int INSTR_W = 16; // Instruction word width

	// Major opcode in the two top bits
	typedef enum logic [1:0] {
		OP_LD  = 2'd0,
		OP_ST  = 2'd1,
		OP_IMM = 2'd2, // LI and branches
		OP_ALU = 2'd3
	} op_t;

	typedef struct packed {
		op_t        op;
		logic [2:0] ra;
		logic [2:0] rb;     // Also the branch condition
		logic [3:0] alu_op;
		logic [3:0] d_low;  // Low nibble of displacement
	} instr_t;

	typedef struct packed {
		logic s; // Sign
		logic z; // Zero
		logic v; // Overflow
	} flags_t;

	// Decoded command, ALU group keeps the alu_op numbering
	typedef enum logic [4:0] {
		CMD_ADD = 5'd0,
		CMD_SUB = 5'd1,
		CMD_AND = 5'd2,
		CMD_OR  = 5'd3,
		CMD_XOR = 5'd4,
		CMD_CMP = 5'd5,
		CMD_MOV = 5'd6,
		CMD_SLL = 5'd8,
		CMD_SLR = 5'd9,
		CMD_SRL = 5'd10,
		CMD_SRA = 5'd11,
		CMD_IN  = 5'd12,
		CMD_OUT = 5'd13,
		CMD_HLT = 5'd15,
		CMD_LD  = 5'd16,
		CMD_ST  = 5'd17,
		CMD_LI  = 5'd18,
		CMD_B   = 5'd19,
		CMD_BE  = 5'd20,
		CMD_BLT = 5'd21,
		CMD_BLE = 5'd22,
		CMD_BNE = 5'd23,
		CMD_NOP = 5'd31 // Also an untaken branch
	} cmd_t;

	typedef logic [5:0] alu_sel_t; // To the ALU control block

endpackage
